// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_rx_ddc -Mdir obj_dir -o sim_rx_ddc

run: compile
	@out="$$(./obj_dir/sim_rx_ddc)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== hw/channel_feed.sv ====
/*
 * Per-channel source select and decimation window counter.
 * Channel c takes ADC input c mod 4; loopback and counter only touch channels 0 and 1.
 */
`timescale 1ns/1ps

module channel_feed #(
   parameter int NUM_CHAN = 4
) (
   input  logic                            clk64,
   input  logic                            rx_dsp_reset,
   input  logic                            i_adc_valid,
   input  logic [rx_ddc_pkg::ADC_W-1:0]    i_rx_a_a,
   input  logic [rx_ddc_pkg::ADC_W-1:0]    i_rx_b_a,
   input  logic [rx_ddc_pkg::ADC_W-1:0]    i_rx_a_b,
   input  logic [rx_ddc_pkg::ADC_W-1:0]    i_rx_b_b,
   input  rx_ddc_pkg::sample_t             i_tx_i,
   input  rx_ddc_pkg::sample_t             i_tx_q,
   input  logic                            i_tx_strobe,
   input  logic                            i_loopback,
   input  logic                            i_counter,
   input  logic [7:0]                      i_decim_rate,
   output rx_ddc_pkg::sample_t             o_feed_sample [NUM_CHAN],
   output logic                            o_feed_valid,
   output logic                            o_feed_dump
);

   logic [rx_ddc_pkg::ADC_W-1:0] adc_word [4];
   rx_ddc_pkg::sample_t          tx_i_q;
   rx_ddc_pkg::sample_t          tx_q_q;
   rx_ddc_pkg::sample_t          debug_cnt;
   rx_ddc_pkg::sample_t          sel_sample [NUM_CHAN];
   logic [7:0]                   rate_q;
   logic [7:0]                   win_cnt;
   logic [7:0]                   win_base;
   logic                         win_last;

   assign adc_word[0] = i_rx_a_a;
   assign adc_word[1] = i_rx_b_a;
   assign adc_word[2] = i_rx_a_b;
   assign adc_word[3] = i_rx_b_b;

   // Latest transmit pair for loopback
   always_ff @(posedge clk64)
   begin
      if (i_tx_strobe)
      begin
         tx_i_q <= i_tx_i;
         tx_q_q <= i_tx_q;
      end
   end

   always_comb
   begin
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         // ADC word sits in the top bits of the sample
         sel_sample[c] = rx_ddc_pkg::sample_t'($signed(adc_word[c % 4])) <<< 4;
         if (i_counter && c < 2)
            sel_sample[c] = debug_cnt + rx_ddc_pkg::sample_t'(c);
         else if (i_loopback && c == 0)
            sel_sample[c] = tx_i_q;
         else if (i_loopback && c == 1)
            sel_sample[c] = tx_q_q;
      end
   end

   // A new rate restarts the window, counting this cycle's sample as its first
   assign win_base = (i_decim_rate != rate_q) ? 8'd0 : win_cnt;
   assign win_last = (win_base == i_decim_rate - 8'd1);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         rate_q       <= 8'd1;
         win_cnt      <= 8'd0;
         debug_cnt    <= '0;
         o_feed_valid <= 1'b0;
         o_feed_dump  <= 1'b0;
      end
      else
      begin
         rate_q       <= i_decim_rate;
         o_feed_valid <= i_adc_valid;
         o_feed_dump  <= i_adc_valid && win_last;
         if (i_adc_valid)
         begin
            win_cnt   <= win_last ? 8'd0 : win_base + 8'd1;
            debug_cnt <= debug_cnt + rx_ddc_pkg::sample_t'(2);
         end
         else
            win_cnt <= win_base;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (i_adc_valid)
         o_feed_sample <= sel_sample;
   end

endmodule

// ==== hw/decim_channel.sv ====
/*
 * Boxcar decimator for one channel, saturated to 16 bits on dump.
 * The accumulator covers windows of up to 255 samples without wrapping.
 */
`timescale 1ns/1ps

module decim_channel (
   input  logic                 clk64,
   input  logic                 rx_dsp_reset,
   input  rx_ddc_pkg::sample_t  i_sample,
   input  logic                 i_valid,
   input  logic                 i_dump,
   output rx_ddc_pkg::sample_t  o_result,
   output logic                 o_result_valid
);

   localparam int ACC_W = rx_ddc_pkg::SAMPLE_W + 8;
   localparam logic signed [ACC_W-1:0] SAT_MAX =
      ACC_W'((1 << (rx_ddc_pkg::SAMPLE_W - 1)) - 1);
   localparam logic signed [ACC_W-1:0] SAT_MIN = -SAT_MAX - 1;

   logic signed [ACC_W-1:0] acc;
   logic signed [ACC_W-1:0] sum;
   rx_ddc_pkg::sample_t     sat;

   assign sum = acc + ACC_W'(i_sample);

   always_comb
   begin
      if (sum > SAT_MAX)
         sat = rx_ddc_pkg::sample_t'(SAT_MAX);
      else if (sum < SAT_MIN)
         sat = rx_ddc_pkg::sample_t'(SAT_MIN);
      else
         sat = rx_ddc_pkg::sample_t'(sum);
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         acc            <= '0;
         o_result_valid <= 1'b0;
      end
      else
      begin
         o_result_valid <= i_valid && i_dump;
         // Dump closes the window with this sample included
         if (i_valid)
            acc <= i_dump ? '0 : sum;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (i_valid && i_dump)
         o_result <= sat;
   end

endmodule

// ==== hw/rx_ddc_pkg.sv ====
/*
 * Shared widths, serial register addresses and the settings-word layouts.
 * Reserved bits of a settings word are ignored on write.
 */
package rx_ddc_pkg;

   localparam int SAMPLE_W  = 16;
   localparam int ADC_W     = 12;
   localparam int ADDR_W    = 7;
   localparam int DATA_W    = 32;
   // Channel index and channel count width
   localparam int NUMCHAN_W = 3;

   localparam logic [ADDR_W-1:0] ADDR_MODE    = 7'd13;
   localparam logic [ADDR_W-1:0] ADDR_RX_RATE = 7'd3;

   // Mode register layout
   typedef struct packed {
      logic [DATA_W-3:0] reserved;
      logic              counter;
      logic              loopback;
   } mode_view_t;

   // Receive rate register layout
   typedef struct packed {
      logic [DATA_W-12:0]    reserved;
      logic [NUMCHAN_W-1:0]  rx_numchan;
      logic [7:0]            decim_rate;
   } rate_view_t;

   // One serial data word, read through the view its address selects
   typedef union packed {
      mode_view_t mode;
      rate_view_t rate;
   } settings_word_t;

   typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

// ==== hw/rx_ddc_top.sv ====
/*
 * Receive sample path top: settings, source select, decimators and packer.
 * Every channel uses the same window, so all channels dump together.
 */
`timescale 1ns/1ps

module rx_ddc_top #(
   parameter int NUM_CHAN   = 4,
   parameter int FIFO_DEPTH = 16,
   parameter int CREDIT_MAX = 8
) (
   input  logic                                clk64,
   input  logic                                rx_dsp_reset,
   input  logic                                i_serial_strobe,
   input  logic [rx_ddc_pkg::ADDR_W-1:0]       i_serial_addr,
   input  logic [rx_ddc_pkg::DATA_W-1:0]       i_serial_data,
   input  logic [rx_ddc_pkg::ADC_W-1:0]        i_rx_a_a,
   input  logic [rx_ddc_pkg::ADC_W-1:0]        i_rx_b_a,
   input  logic [rx_ddc_pkg::ADC_W-1:0]        i_rx_a_b,
   input  logic [rx_ddc_pkg::ADC_W-1:0]        i_rx_b_b,
   input  logic                                i_adc_valid,
   input  rx_ddc_pkg::sample_t                 i_tx_i,
   input  rx_ddc_pkg::sample_t                 i_tx_q,
   input  logic                                i_tx_strobe,
   input  logic                                i_credit,
   input  logic                                i_clear_status,
   output rx_ddc_pkg::sample_t                 o_word,
   output logic [rx_ddc_pkg::NUMCHAN_W-1:0]    o_word_chan,
   output logic                                o_word_valid,
   output logic                                o_rx_overrun
);

   logic                               loopback;
   logic                               counter;
   logic [7:0]                         decim_rate;
   logic [rx_ddc_pkg::NUMCHAN_W-1:0]   rx_numchan;
   rx_ddc_pkg::sample_t                feed_sample [NUM_CHAN];
   logic                               feed_valid;
   logic                               feed_dump;
   rx_ddc_pkg::sample_t                result [NUM_CHAN];
   logic [NUM_CHAN-1:0]                result_valid;

   setting_regs #(.NUM_CHAN(NUM_CHAN)) u_setting_regs (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
      .i_serial_strobe(i_serial_strobe), .i_serial_addr(i_serial_addr),
      .i_serial_data(i_serial_data),
      .o_loopback(loopback), .o_counter(counter),
      .o_decim_rate(decim_rate), .o_rx_numchan(rx_numchan)
   );

   channel_feed #(.NUM_CHAN(NUM_CHAN)) u_channel_feed (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset), .i_adc_valid(i_adc_valid),
      .i_rx_a_a(i_rx_a_a), .i_rx_b_a(i_rx_b_a), .i_rx_a_b(i_rx_a_b), .i_rx_b_b(i_rx_b_b),
      .i_tx_i(i_tx_i), .i_tx_q(i_tx_q), .i_tx_strobe(i_tx_strobe),
      .i_loopback(loopback), .i_counter(counter), .i_decim_rate(decim_rate),
      .o_feed_sample(feed_sample), .o_feed_valid(feed_valid), .o_feed_dump(feed_dump)
   );

   for (genvar c = 0; c < NUM_CHAN; c++)
   begin : g_chan
      decim_channel u_decim_channel (
         .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
         .i_sample(feed_sample[c]), .i_valid(feed_valid), .i_dump(feed_dump),
         .o_result(result[c]), .o_result_valid(result_valid[c])
      );
   end

   // Channel 0's strobe stands for the whole set
   sample_packer #(
      .NUM_CHAN(NUM_CHAN), .FIFO_DEPTH(FIFO_DEPTH), .CREDIT_MAX(CREDIT_MAX)
   ) u_sample_packer (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
      .i_result(result), .i_result_valid(result_valid[0]), .i_rx_numchan(rx_numchan),
      .i_credit(i_credit), .i_clear_status(i_clear_status),
      .o_word(o_word), .o_word_chan(o_word_chan), .o_word_valid(o_word_valid),
      .o_rx_overrun(o_rx_overrun)
   );

endmodule

// ==== hw/sample_packer.sv ====
/*
 * Result FIFO with credit-gated output and sticky overrun flag.
 * FIFO_DEPTH must be a power of two no smaller than NUM_CHAN.
 */
`timescale 1ns/1ps

module sample_packer #(
   parameter int NUM_CHAN   = 4,
   parameter int FIFO_DEPTH = 16,
   parameter int CREDIT_MAX = 8
) (
   input  logic                                clk64,
   input  logic                                rx_dsp_reset,
   input  rx_ddc_pkg::sample_t                 i_result [NUM_CHAN],
   input  logic                                i_result_valid,
   input  logic [rx_ddc_pkg::NUMCHAN_W-1:0]    i_rx_numchan,
   input  logic                                i_credit,
   input  logic                                i_clear_status,
   output rx_ddc_pkg::sample_t                 o_word,
   output logic [rx_ddc_pkg::NUMCHAN_W-1:0]    o_word_chan,
   output logic                                o_word_valid,
   output logic                                o_rx_overrun
);

   localparam int PTR_W  = $clog2(FIFO_DEPTH);
   localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
   localparam int CRED_W = $clog2(CREDIT_MAX + 1);
   localparam int CHAN_W = rx_ddc_pkg::NUMCHAN_W;

   rx_ddc_pkg::sample_t fifo_word [FIFO_DEPTH];
   logic [CHAN_W-1:0]   fifo_chan [FIFO_DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [CNT_W-1:0]    count;
   logic [CNT_W-1:0]    free;
   logic [CNT_W-1:0]    push_cnt;
   logic [CRED_W-1:0]   credits;
   logic                fits;
   logic                push;
   logic                pop;

   // Whole set goes in or none of it does
   assign free     = CNT_W'(FIFO_DEPTH) - count;
   assign fits     = (free >= CNT_W'(i_rx_numchan));
   assign push     = i_result_valid && fits;
   assign push_cnt = push ? CNT_W'(i_rx_numchan) : '0;

   // One word per credit
   assign pop          = (credits != '0) && (count != '0);
   assign o_word_valid = pop;
   assign o_word       = fifo_word[rd_ptr];
   assign o_word_chan  = fifo_chan[rd_ptr];

   // Channels land in consecutive entries in channel order
   always_ff @(posedge clk64)
   begin
      if (push)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            if (c < int'(i_rx_numchan))
            begin
               fifo_word[wr_ptr + PTR_W'(c)] <= i_result[c];
               fifo_chan[wr_ptr + PTR_W'(c)] <= CHAN_W'(c);
            end
         end
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         credits      <= '0;
         o_rx_overrun <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + PTR_W'(i_rx_numchan);
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count   <= count + push_cnt - CNT_W'(pop);
         credits <= credits + CRED_W'(i_credit) - CRED_W'(pop);
         // A drop in the same cycle as a clear keeps the flag set
         if (i_result_valid && !fits)
            o_rx_overrun <= 1'b1;
         else if (i_clear_status)
            o_rx_overrun <= 1'b0;
      end
   end

   // Sink grants no credit once the count is full
   a_credit_limit: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (i_credit && !pop) |-> (credits < CRED_W'(CREDIT_MAX)));

   // Occupancy stays within the buffer and agrees with the pointer distance
   a_fifo_no_overflow: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (count <= CNT_W'(FIFO_DEPTH)) && (wr_ptr - rd_ptr == PTR_W'(count)));

endmodule

// ==== hw/setting_regs.sv ====
/*
 * Mode and receive-rate registers written over the serial strobe bus.
 * A write is visible on the outputs one cycle after its strobe.
 */
`timescale 1ns/1ps

module setting_regs #(
   parameter int NUM_CHAN = 4
) (
   input  logic                                  clk64,
   input  logic                                  rx_dsp_reset,
   input  logic                                  i_serial_strobe,
   input  logic [rx_ddc_pkg::ADDR_W-1:0]         i_serial_addr,
   input  rx_ddc_pkg::settings_word_t            i_serial_data,
   output logic                                  o_loopback,
   output logic                                  o_counter,
   output logic [7:0]                            o_decim_rate,
   output logic [rx_ddc_pkg::NUMCHAN_W-1:0]      o_rx_numchan
);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_loopback   <= 1'b0;
         o_counter    <= 1'b0;
         o_decim_rate <= 8'd1;
         o_rx_numchan <= 1;
      end
      else if (i_serial_strobe)
      begin
         case (i_serial_addr)
            rx_ddc_pkg::ADDR_MODE:
            begin
               o_loopback <= i_serial_data.mode.loopback;
               o_counter  <= i_serial_data.mode.counter;
            end
            rx_ddc_pkg::ADDR_RX_RATE:
            begin
               o_decim_rate <= i_serial_data.rate.decim_rate;
               o_rx_numchan <= i_serial_data.rate.rx_numchan;
            end
            // Other addresses belong to blocks outside this path
            default:
            begin
            end
         endcase
      end
   end

   // Rate writes must give a usable window and a channel count the packer can hold
   a_rate_write_legal: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (i_serial_strobe && i_serial_addr == rx_ddc_pkg::ADDR_RX_RATE) |->
      (i_serial_data.rate.decim_rate != 8'd0 && i_serial_data.rate.rx_numchan != 0 &&
       int'(i_serial_data.rate.rx_numchan) <= NUM_CHAN));

endmodule

// ==== sources.f ====
hw/rx_ddc_pkg.sv
hw/setting_regs.sv
hw/channel_feed.sv
hw/decim_channel.sv
hw/sample_packer.sv
hw/rx_ddc_top.sv
verification/tb_rx_ddc.sv

// ==== verification/rx_ddc_testdata.txt ====
# T name | W addr data | A count a_a b_a a_b b_b | R count (LFSR) | L tx_i tx_q
# C credits | X clear | E count word chan | O overrun | N no words expected
T counter
W 0d 00000002
W 03 00000201
A 3 000 000 000 000
C 6
E 1 0000 0
E 1 0001 1
E 1 0002 0
E 1 0003 1
E 1 0004 0
E 1 0005 1
T loopback
W 0d 00000001
L 0100 ff00
W 03 00000203
A 3 000 000 000 000
C 2
E 1 0300 0
E 1 fd00 1
T adc_path
W 0d 00000000
W 03 00000404
A 1 001 010 fff 100
A 1 002 010 fff 080
A 1 003 010 fff 040
A 1 004 010 fff 020
C 4
E 1 00a0 0
E 1 0400 1
E 1 ffc0 2
E 1 1e00 3
T saturation
W 03 00000110
A 16 7ff 7ff 7ff 7ff
A 16 800 800 800 800
C 2
E 1 7fff 0
E 1 8000 0
T credits
W 03 00000101
A 1 001 000 000 000
A 1 002 000 000 000
A 1 003 000 000 000
N
C 2
E 1 0010 0
E 1 0020 0
N
C 1
E 1 0030 0
T overrun
A 16 005 000 000 000
R 2
O 1
C 8
E 8 0050 0
C 8
E 8 0050 0
N
X
O 0
A 1 009 000 000 000
C 1
E 1 0090 0
N
T reg_decode
W 05 00000402
A 1 001 002 003 004
C 1
E 1 0010 0
N
W 03 00000201
A 1 001 002 003 004
C 2
E 1 0010 0
E 1 0020 1
N

// ==== verification/tb_rx_ddc.sv ====
/*
 * Replays verification/rx_ddc_testdata.txt against rx_ddc_top and checks every output word.
 * Credits granted in the data file must never take the DUT count above 8.
 */
`timescale 1ns/1ps

module tb_rx_ddc;

   logic        clk64;
   logic        rx_dsp_reset;
   logic        i_serial_strobe;
   logic [6:0]  i_serial_addr;
   logic [31:0] i_serial_data;
   logic [11:0] i_rx_a_a;
   logic [11:0] i_rx_b_a;
   logic [11:0] i_rx_a_b;
   logic [11:0] i_rx_b_b;
   logic        i_adc_valid;
   logic [15:0] i_tx_i;
   logic [15:0] i_tx_q;
   logic        i_tx_strobe;
   logic        i_credit;
   logic        i_clear_status;
   logic [15:0] o_word;
   logic [2:0]  o_word_chan;
   logic        o_word_valid;
   logic        o_rx_overrun;

   logic [15:0]      got_word [$];
   logic [2:0]       got_chan [$];
   logic [31:0]      lfsr_state;
   reg   [8*32-1:0]  test_name;
   bit               in_test;
   int               test_errors;
   int               total_errors;
   int               tests_run;
   int               tests_failed;
   int               n_lines;

   rx_ddc_top i_dut (
      .clk64(clk64), .rx_dsp_reset(rx_dsp_reset),
      .i_serial_strobe(i_serial_strobe), .i_serial_addr(i_serial_addr),
      .i_serial_data(i_serial_data),
      .i_rx_a_a(i_rx_a_a), .i_rx_b_a(i_rx_b_a), .i_rx_a_b(i_rx_a_b), .i_rx_b_b(i_rx_b_b),
      .i_adc_valid(i_adc_valid), .i_tx_i(i_tx_i), .i_tx_q(i_tx_q), .i_tx_strobe(i_tx_strobe),
      .i_credit(i_credit), .i_clear_status(i_clear_status),
      .o_word(o_word), .o_word_chan(o_word_chan), .o_word_valid(o_word_valid),
      .o_rx_overrun(o_rx_overrun)
   );

   initial
   begin
      clk64 = 1'b0;
      forever #4 clk64 = ~clk64;
   end

   // Collect every word the DUT releases
   always @(posedge clk64)
   begin
      if (!rx_dsp_reset && o_word_valid)
      begin
         got_word.push_back(o_word);
         got_chan.push_back(o_word_chan);
      end
   end

   initial
   begin
      wait (n_lines > 0);
      repeat (n_lines * 200) @(posedge clk64);
      $display("watchdog: run did not finish within %0d cycles", n_lines * 200);
      $display("Test failures found");
      $finish;
   end

   task automatic step();
      @(posedge clk64);
      #1;
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      i_serial_strobe = 1'b1;
      i_serial_addr   = addr;
      i_serial_data   = data;
      step();
      i_serial_strobe = 1'b0;
   endtask

   task automatic feed_adc(input int n, input logic [11:0] a0, input logic [11:0] a1,
                           input logic [11:0] a2, input logic [11:0] a3);
      i_rx_a_a    = a0;
      i_rx_b_a    = a1;
      i_rx_a_b    = a2;
      i_rx_b_b    = a3;
      i_adc_valid = 1'b1;
      repeat (n) step();
      i_adc_valid = 1'b0;
   endtask

   task automatic feed_random(input int n);
      logic [11:0] v [4];
      for (int k = 0; k < n; k++)
      begin
         for (int c = 0; c < 4; c++)
         begin
            v[c] = '0;
            for (int b = 0; b < 12; b++)
            begin
               lfsr_state = lfsr_next(lfsr_state);
               v[c] = {v[c][10:0], lfsr_state[0]};
            end
         end
         feed_adc(1, v[0], v[1], v[2], v[3]);
      end
   endtask

   task automatic load_tx(input logic [15:0] tx_i, input logic [15:0] tx_q);
      i_tx_i      = tx_i;
      i_tx_q      = tx_q;
      i_tx_strobe = 1'b1;
      step();
      i_tx_strobe = 1'b0;
   endtask

   task automatic grant_credits(input int n);
      i_credit = 1'b1;
      repeat (n) step();
      i_credit = 1'b0;
   endtask

   task automatic clear_overrun();
      i_clear_status = 1'b1;
      step();
      i_clear_status = 1'b0;
   endtask

   task automatic expect_words(input int n, input logic [15:0] w, input logic [2:0] ch);
      int          waited;
      logic [15:0] aw;
      logic [2:0]  ac;
      for (int k = 0; k < n; k++)
      begin
         waited = 0;
         while (got_word.size() == 0 && waited < 100)
         begin
            step();
            waited++;
         end
         if (got_word.size() == 0)
         begin
            $display("%0s: expected output word %h never arrived", test_name, w);
            test_errors++;
            return;
         end
         aw = got_word.pop_front();
         ac = got_chan.pop_front();
         if (aw !== w)
         begin
            $display("error %0s: word expected %h actual %h", test_name, w, aw);
            test_errors++;
         end
         if (ac !== ch)
         begin
            $display("error %0s: channel expected %0d actual %0d", test_name, ch, ac);
            test_errors++;
         end
      end
   endtask

   task automatic check_overrun(input logic exp);
      repeat (4) step();
      if (o_rx_overrun !== exp)
      begin
         $display("error %0s: overrun expected %0d actual %0d", test_name, exp, o_rx_overrun);
         test_errors++;
      end
   endtask

   task automatic check_idle();
      repeat (16) step();
      if (got_word.size() != 0)
      begin
         $display("%0s: %0d output words appeared that were not expected",
                  test_name, got_word.size());
         test_errors++;
         got_word.delete();
         got_chan.delete();
      end
   endtask

   task automatic finish_test();
      if (in_test)
      begin
         tests_run++;
         total_errors += test_errors;
         if (test_errors == 0)
            $display("pass  %0s", test_name);
         else
         begin
            $display("FAIL  %0s (%0d errors)", test_name, test_errors);
            tests_failed++;
         end
      end
   endtask

   initial
   begin
      int    fd;
      int    a;
      int    b;
      int    c;
      int    d;
      int    e;
      int    f;
      int    lines;
      string line;
      byte   cmd;
      rx_dsp_reset    = 1'b1;
      i_serial_strobe = 1'b0;
      i_serial_addr   = '0;
      i_serial_data   = '0;
      i_rx_a_a        = '0;
      i_rx_b_a        = '0;
      i_rx_a_b        = '0;
      i_rx_b_b        = '0;
      i_adc_valid     = 1'b0;
      i_tx_i          = '0;
      i_tx_q          = '0;
      i_tx_strobe     = 1'b0;
      i_credit        = 1'b0;
      i_clear_status  = 1'b0;
      lfsr_state      = 32'h67d1;
      in_test         = 1'b0;
      test_errors     = 0;
      total_errors    = 0;
      tests_run       = 0;
      tests_failed    = 0;
      n_lines         = 0;
      lines           = 0;
      test_name       = "none";
      fd = $fopen("verification/rx_ddc_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("could not open verification/rx_ddc_testdata.txt");
         $display("Test failures found");
         $finish;
      end
      else
      begin
         // First pass only sizes the watchdog
         while ($fgets(line, fd) != 0)
            lines++;
         n_lines = lines;
         $fclose(fd);
         fd = $fopen("verification/rx_ddc_testdata.txt", "r");
         repeat (8) @(posedge clk64);
         #1;
         rx_dsp_reset = 1'b0;
         step();
         while ($fgets(line, fd) != 0)
         begin
            cmd = line.getc(0);
            case (cmd)
               "T":
               begin
                  finish_test();
                  a = $sscanf(line, "T %s", test_name);
                  in_test     = 1'b1;
                  test_errors = 0;
               end
               "W":
               begin
                  a = $sscanf(line, "W %h %h", b, c);
                  write_reg(b[6:0], c);
               end
               "A":
               begin
                  a = $sscanf(line, "A %d %h %h %h %h", b, c, d, e, f);
                  feed_adc(b, c[11:0], d[11:0], e[11:0], f[11:0]);
               end
               "R":
               begin
                  a = $sscanf(line, "R %d", b);
                  feed_random(b);
               end
               "L":
               begin
                  a = $sscanf(line, "L %h %h", b, c);
                  load_tx(b[15:0], c[15:0]);
               end
               "C":
               begin
                  a = $sscanf(line, "C %d", b);
                  grant_credits(b);
               end
               "X": clear_overrun();
               "E":
               begin
                  a = $sscanf(line, "E %d %h %d", b, c, d);
                  expect_words(b, c[15:0], d[2:0]);
               end
               "O":
               begin
                  a = $sscanf(line, "O %d", b);
                  check_overrun(b[0]);
               end
               "N": check_idle();
               default:
               begin
               end
            endcase
         end
         $fclose(fd);
         finish_test();
         $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                  total_errors);
         if (tests_failed == 0 && total_errors == 0)
            $display("All tests passed!");
         else
            $display("Test failures found");
         $finish;
      end
   end

endmodule
